// ==== verilog.f ====
rtl/lc3b_isa_pkg.sv
rtl/rename_pkg.sv
rtl/rf_ports_if.sv
rtl/two_write_regfile.sv
rtl/regfile_data.sv
rtl/regfile.sv
rtl/issue_rename.sv
rtl/commit_update.sv
rtl/rename_status_top.sv
tests/rename_status_checker.sv
tests/rename_status_props.sv
tests/rename_status_tb.sv

// ==== tests/rename_status_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_status_tb;
    import lc3b_isa_pkg::*;
    import rename_pkg::*;

    // inputs for one cycle and the outputs seen before its rising edge
    typedef struct packed {
        logic         flush;
        logic         issue_valid;
        lc3b_reg      issue_sr1;
        lc3b_reg      issue_sr2;
        lc3b_reg      issue_dest;
        lc3b_rob_addr issue_tag;
        logic         commit_valid;
        lc3b_reg      commit_dest;
        lc3b_rob_addr commit_tag;
        lc3b_word     commit_value;
        operand_t     exp_opnd1;
        operand_t     exp_opnd2;
        logic         exp_dest_busy;
    } stim_row_t;

    localparam int max_rows = 32;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         issue_valid;
    lc3b_reg      issue_sr1;
    lc3b_reg      issue_sr2;
    lc3b_reg      issue_dest;
    lc3b_rob_addr issue_tag;
    logic         commit_valid;
    lc3b_reg      commit_dest;
    lc3b_rob_addr commit_tag;
    lc3b_word     commit_value;
    operand_t     opnd1;
    operand_t     opnd2;
    logic         dest_busy;

    // checker side
    logic         check_en;
    int           row_idx;
    operand_t     exp_opnd1;
    operand_t     exp_opnd2;
    logic         exp_dest_busy;
    logic         armed;
    int           checked;
    int           failed_rows;

    stim_row_t    rows [max_rows];
    int           n_rows;
    bit           timed_out;

    rename_status_top rename_status_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_sr1    (issue_sr1),
        .issue_sr2    (issue_sr2),
        .issue_dest   (issue_dest),
        .issue_tag    (issue_tag),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_tag   (commit_tag),
        .commit_value (commit_value),
        .opnd1        (opnd1),
        .opnd2        (opnd2),
        .dest_busy    (dest_busy)
    );

    rename_status_checker checker_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .check_en      (check_en),
        .row_idx       (row_idx),
        .opnd1         (opnd1),
        .opnd2         (opnd2),
        .dest_busy     (dest_busy),
        .exp_opnd1     (exp_opnd1),
        .exp_opnd2     (exp_opnd2),
        .exp_dest_busy (exp_dest_busy),
        .armed         (armed),
        .checked       (checked),
        .failed_rows   (failed_rows)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // register is free, operand carries its committed value
    function automatic operand_t free_opnd(input lc3b_word value);
        operand_t op;
        op.ready = 1'b1;
        op.tag   = '0;
        op.value = value;
        return op;
    endfunction

    // register is renamed, operand waits on this ROB entry
    function automatic operand_t busy_opnd(input lc3b_rob_addr tag);
        operand_t op;
        op.ready = 1'b0;
        op.tag   = tag;
        op.value = '0;
        return op;
    endfunction

    task automatic add_row(
        input logic         fl,
        input logic         iv,
        input lc3b_reg      s1,
        input lc3b_reg      s2,
        input lc3b_reg      d,
        input lc3b_rob_addr itag,
        input logic         cv,
        input lc3b_reg      cd,
        input lc3b_rob_addr ctag,
        input lc3b_word     cval,
        input operand_t     e1,
        input operand_t     e2,
        input logic         edb
    );
        rows[n_rows] = '{fl, iv, s1, s2, d, itag, cv, cd, ctag, cval, e1, e2, edb};
        n_rows++;
    endtask

    // expected columns follow the status rules by hand
    // fl iv s1 s2 d itag  cv cd ctag value  opnd1 opnd2 dest_busy
    task automatic build_table();
        n_rows = 0;
        // all registers ready with 0 out of reset
        add_row(0, 0, 0, 1, 0, 0, 0, 0, 0, 16'h0000, free_opnd(16'h0), free_opnd(16'h0), 0);
        add_row(0, 0, 2, 3, 2, 0, 0, 0, 0, 16'h0000, free_opnd(16'h0), free_opnd(16'h0), 0);
        add_row(0, 0, 4, 5, 4, 0, 0, 0, 0, 16'h0000, free_opnd(16'h0), free_opnd(16'h0), 0);
        add_row(0, 0, 6, 7, 6, 0, 0, 0, 0, 16'h0000, free_opnd(16'h0), free_opnd(16'h0), 0);
        // R3 renamed to entry 5, then read back as waiting
        add_row(0, 1, 3, 4, 3, 5, 0, 0, 0, 16'h0000, free_opnd(16'h0), free_opnd(16'h0), 0);
        add_row(0, 0, 3, 4, 3, 0, 0, 0, 0, 16'h0000, busy_opnd(5), free_opnd(16'h0), 1);
        // matching commit frees R3
        add_row(0, 0, 3, 0, 3, 0, 1, 3, 5, 16'h1234, busy_opnd(5), free_opnd(16'h0), 1);
        add_row(0, 0, 3, 3, 3, 0, 0, 0, 0, 16'h0000, free_opnd(16'h1234),
                free_opnd(16'h1234), 0);
        // R2 renamed twice, stale commit of entry 1 keeps it busy on entry 4
        add_row(0, 1, 2, 3, 2, 1, 0, 0, 0, 16'h0000, free_opnd(16'h0), free_opnd(16'h1234), 0);
        add_row(0, 1, 2, 5, 2, 4, 0, 0, 0, 16'h0000, busy_opnd(1), free_opnd(16'h0), 1);
        add_row(0, 0, 2, 2, 2, 0, 1, 2, 1, 16'hbeef, busy_opnd(4), busy_opnd(4), 1);
        // flush frees R2, which then shows the value of the stale commit
        add_row(1, 0, 2, 3, 2, 0, 0, 0, 0, 16'h0000, busy_opnd(4), free_opnd(16'h1234), 1);
        add_row(0, 0, 2, 0, 2, 0, 1, 2, 4, 16'hcafe, free_opnd(16'hbeef), free_opnd(16'h0), 0);
        // R6 renamed to entry 2, then issue and commit hit R6 together
        add_row(0, 1, 2, 3, 6, 2, 0, 0, 0, 16'h0000, free_opnd(16'hcafe),
                free_opnd(16'h1234), 0);
        add_row(0, 1, 6, 2, 6, 7, 1, 6, 2, 16'h0066, busy_opnd(2), free_opnd(16'hcafe), 1);
        add_row(0, 0, 6, 6, 6, 0, 0, 0, 0, 16'h0000, busy_opnd(7), busy_opnd(7), 1);
        // R1 renamed, then a flush frees everything
        add_row(0, 1, 1, 6, 1, 3, 0, 0, 0, 16'h0000, free_opnd(16'h0), busy_opnd(7), 0);
        add_row(1, 0, 1, 6, 4, 0, 0, 0, 0, 16'h0000, busy_opnd(3), busy_opnd(7), 0);
        add_row(0, 0, 6, 3, 1, 0, 0, 0, 0, 16'h0000, free_opnd(16'h0066),
                free_opnd(16'h1234), 0);
        add_row(0, 0, 2, 1, 6, 0, 0, 0, 0, 16'h0000, free_opnd(16'hcafe), free_opnd(16'h0), 0);
        add_row(0, 0, 0, 7, 5, 0, 0, 0, 0, 16'h0000, free_opnd(16'h0), free_opnd(16'h0), 0);
    endtask

    task automatic drive_idle();
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue_sr1     = '0;
        issue_sr2     = '0;
        issue_dest    = '0;
        issue_tag     = '0;
        commit_valid  = 1'b0;
        commit_dest   = '0;
        commit_tag    = '0;
        commit_value  = '0;
        check_en      = 1'b0;
        row_idx       = 0;
        exp_opnd1     = '0;
        exp_opnd2     = '0;
        exp_dest_busy = 1'b0;
    endtask

    task automatic apply_row(input int i);
        flush         = rows[i].flush;
        issue_valid   = rows[i].issue_valid;
        issue_sr1     = rows[i].issue_sr1;
        issue_sr2     = rows[i].issue_sr2;
        issue_dest    = rows[i].issue_dest;
        issue_tag     = rows[i].issue_tag;
        commit_valid  = rows[i].commit_valid;
        commit_dest   = rows[i].commit_dest;
        commit_tag    = rows[i].commit_tag;
        commit_value  = rows[i].commit_value;
        exp_opnd1     = rows[i].exp_opnd1;
        exp_opnd2     = rows[i].exp_opnd2;
        exp_dest_busy = rows[i].exp_dest_busy;
        row_idx       = i;
        check_en      = 1'b1;
    endtask

    initial begin
        int waited;
        rst_n     = 1'b0;
        timed_out = 1'b0;
        drive_idle();
        build_table();
        // two reset edges
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        waited = 0;
        while (!armed && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (!armed) begin
            timed_out = 1'b1;
            $display("checker never saw reset released");
        end

        for (int i = 0; i < n_rows && !timed_out; i++) begin
            @(negedge clk);
            apply_row(i);
            // the checker samples this row just before the next rising edge
            waited = 0;
            while (checked < i + 1 && waited < 5) begin
                @(posedge clk);
                waited++;
            end
            if (checked < i + 1) begin
                timed_out = 1'b1;
                $display("row %0d was never checked before the timeout", i);
            end
        end

        @(negedge clk);
        drive_idle();
        $display("rows checked %0d of %0d, rows failed %0d, assertion failures %0d",
                 checked, n_rows, failed_rows,
                 rename_status_top_i.regfile_i.props_i.violations);
        if (timed_out || checked != n_rows || failed_rows != 0 ||
            rename_status_top_i.regfile_i.props_i.violations != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule : rename_status_tb

`default_nettype wire

// ==== tests/rename_status_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_status_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  flush,
    input logic                  ld_busy,
    input lc3b_isa_pkg::lc3b_reg dest,
    // busy bit of every register, R7 in the msb
    input logic [7:0]            busy_vec
);
    // bumped on each failing assertion
    int violations = 0;

    // reset clears the whole busy array
    reset_clears_busy: assert property (@(posedge clk) !rst_n |=> busy_vec == '0)
        else begin
            $error("busy bit still set after reset");
            violations++;
        end

    // flush beats both write ports
    flush_clears_busy: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> busy_vec == '0)
        else begin
            $error("busy bit still set after flush");
            violations++;
        end

    // issued destination is busy one cycle later
    issue_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (ld_busy && !flush) |=> busy_vec[$past(dest)])
        else begin
            $error("issued destination not busy on the next cycle");
            violations++;
        end

endmodule : rename_status_props

bind regfile rename_status_props props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .ld_busy  (issue.ld_busy),
    .dest     (issue.dest),
    .busy_vec ({busy_reg.mem[7], busy_reg.mem[6], busy_reg.mem[5], busy_reg.mem[4],
                busy_reg.mem[3], busy_reg.mem[2], busy_reg.mem[1], busy_reg.mem[0]})
);

`default_nettype wire

// ==== tests/rename_status_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_status_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 check_en,
    input  int                   row_idx,
    // DUT outputs
    input  rename_pkg::operand_t opnd1,
    input  rename_pkg::operand_t opnd2,
    input  logic                 dest_busy,
    // expected values of the current row
    input  rename_pkg::operand_t exp_opnd1,
    input  rename_pkg::operand_t exp_opnd2,
    input  logic                 exp_dest_busy,
    output logic                 armed,
    output int                   checked,
    output int                   failed_rows
);
    import rename_pkg::*;

    // only the meaningful field is compared
    // value when ready, producer tag when waiting
    function automatic int operand_errors(input string name, input operand_t act,
                                          input operand_t exp);
        int errs;
        errs = 0;
        if (act.ready !== exp.ready) begin
            $display("Error at %0t: %s.ready expected %0b, got %0b",
                     $time, name, exp.ready, act.ready);
            errs++;
        end else if (exp.ready && act.value !== exp.value) begin
            $display("Error at %0t: %s.value expected %h, got %h",
                     $time, name, exp.value, act.value);
            errs++;
        end else if (!exp.ready && act.tag !== exp.tag) begin
            $display("Error at %0t: %s.tag expected %0d, got %0d",
                     $time, name, exp.tag, act.tag);
            errs++;
        end
        return errs;
    endfunction

    initial begin
        armed       = 1'b0;
        checked     = 0;
        failed_rows = 0;
    end

    // first rising edge with reset released arms the checker
    always @(posedge clk) begin
        armed <= rst_n;
    end

    always @(negedge clk) begin
        int errs;
        // sample 2 ns before the rising edge once the falling-edge drive has settled
        #8;
        if (check_en) begin
            errs = 0;
            errs += operand_errors("opnd1", opnd1, exp_opnd1);
            errs += operand_errors("opnd2", opnd2, exp_opnd2);
            if (dest_busy !== exp_dest_busy) begin
                $display("Error at %0t: dest_busy expected %0b, got %0b",
                         $time, exp_dest_busy, dest_busy);
                errs++;
            end
            if (errs == 0) begin
                $display("row %0d ok", row_idx);
            end else begin
                $display("row %0d failed with %0d mismatches", row_idx, errs);
                failed_rows++;
            end
            checked++;
        end
    end

endmodule : rename_status_checker

`default_nettype wire

// ==== rtl/rename_status_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_status_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    // issue strobe and operands
    input  logic                      issue_valid,
    input  lc3b_isa_pkg::lc3b_reg     issue_sr1,
    input  lc3b_isa_pkg::lc3b_reg     issue_sr2,
    input  lc3b_isa_pkg::lc3b_reg     issue_dest,
    input  rename_pkg::lc3b_rob_addr  issue_tag,
    // commit strobe from the ROB head
    input  logic                      commit_valid,
    input  lc3b_isa_pkg::lc3b_reg     commit_dest,
    input  rename_pkg::lc3b_rob_addr  commit_tag,
    input  lc3b_isa_pkg::lc3b_word    commit_value,
    // renamed operands
    output rename_pkg::operand_t      opnd1,
    output rename_pkg::operand_t      opnd2,
    output logic                      dest_busy
);

    rf_issue_if  issue_bus ();
    rf_commit_if commit_bus ();

    issue_rename issue_rename_i (
        .issue_valid (issue_valid),
        .issue_sr1   (issue_sr1),
        .issue_sr2   (issue_sr2),
        .issue_dest  (issue_dest),
        .issue_tag   (issue_tag),
        .opnd1       (opnd1),
        .opnd2       (opnd2),
        .dest_busy   (dest_busy),
        .rf          (issue_bus.ctrl)
    );

    commit_update commit_update_i (
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_tag   (commit_tag),
        .commit_value (commit_value),
        .rf           (commit_bus.ctrl)
    );

    // status storage shared by both sides
    regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .issue  (issue_bus.file),
        .commit (commit_bus.file)
    );

endmodule : rename_status_top

`default_nettype wire

// ==== rtl/commit_update.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_update (
    input  logic                      commit_valid,
    input  lc3b_isa_pkg::lc3b_reg     commit_dest,
    input  rename_pkg::lc3b_rob_addr  commit_tag,
    input  lc3b_isa_pkg::lc3b_word    commit_value,
    rf_commit_if.ctrl                 rf
);

    // the architectural value is always updated
    assign rf.ld_value = commit_valid;
    assign rf.value    = commit_value;
    assign rf.dest     = commit_dest;

    // release only if this entry is still the latest writer
    // a younger rename keeps the register busy
    // dest_tag is the tag before any same-cycle issue
    assign rf.ld_busy = commit_valid && (rf.dest_tag == commit_tag);

endmodule : commit_update

`default_nettype wire

// ==== rtl/issue_rename.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_rename (
    input  logic                      issue_valid,
    input  lc3b_isa_pkg::lc3b_reg     issue_sr1,
    input  lc3b_isa_pkg::lc3b_reg     issue_sr2,
    input  lc3b_isa_pkg::lc3b_reg     issue_dest,
    input  rename_pkg::lc3b_rob_addr  issue_tag,
    output rename_pkg::operand_t      opnd1,
    output rename_pkg::operand_t      opnd2,
    output logic                      dest_busy,
    rf_issue_if.ctrl                  rf
);
    import rename_pkg::*;

    // a free register hands out its value, a busy one its producer tag
    function automatic operand_t to_operand(input regfile_t status);
        operand_t op;
        op.ready = !status.busy;
        op.tag   = status.rob_entry;
        op.value = status.busy ? '0 : status.data;
        return op;
    endfunction

    // sources read straight through
    assign rf.sr1  = issue_sr1;
    assign rf.sr2  = issue_sr2;
    assign rf.dest = issue_dest;

    // claim the destination for the new ROB entry
    assign rf.ld_busy      = issue_valid;
    assign rf.ld_rob_entry = issue_valid;
    assign rf.rob_entry    = issue_tag;

    assign opnd1     = to_operand(rf.sr1_out);
    assign opnd2     = to_operand(rf.sr2_out);
    // status of dest before this issue lands
    assign dest_busy = rf.dest_out.busy;

endmodule : issue_rename

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    rf_issue_if.file         issue,
    rf_commit_if.file        commit
);
    import lc3b_isa_pkg::*;
    import rename_pkg::*;

    // busy bits per read port
    logic         sr1_busy, sr2_busy, dest_busy;
    // owner tags per read port
    lc3b_rob_addr sr1_tag, sr2_tag, dest_tag;
    // values per read port
    lc3b_word     sr1_val, sr2_val, dest_val;

    // issue sets on port A, commit clears on port B
    two_write_regfile #(.data_width(1), .tag_width($bits(lc3b_reg))) busy_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .load_a   (issue.ld_busy),
        .load_b   (commit.ld_busy),
        .in_a     (1'b1),
        .in_b     (1'b0),
        .sr1      (issue.sr1),
        .sr2      (issue.sr2),
        .dest_a   (issue.dest),
        .dest_b   (commit.dest),
        .reg_a    (sr1_busy),
        .reg_b    (sr2_busy),
        .dest_out (dest_busy)
    );

    // committed values, written from the ROB side
    regfile_data #(.data_width($bits(lc3b_word)), .tag_width($bits(lc3b_reg))) value_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (commit.ld_value),
        .in         (commit.value),
        .sr1        (issue.sr1),
        .sr2        (issue.sr2),
        .dest       (commit.dest),
        .dest_b     (issue.dest),
        .reg_a      (sr1_val),
        .reg_b      (sr2_val),
        .dest_out   (),
        .dest_b_out (dest_val)
    );

    // rename tags, written at issue and compared at commit
    regfile_data #(.data_width(rob_tag_width), .tag_width($bits(lc3b_reg))) rob_entry_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (issue.ld_rob_entry),
        .in         (issue.rob_entry),
        .sr1        (issue.sr1),
        .sr2        (issue.sr2),
        .dest       (issue.dest),
        .dest_b     (commit.dest),
        .reg_a      (sr1_tag),
        .reg_b      (sr2_tag),
        .dest_out   (dest_tag),
        .dest_b_out (commit.dest_tag)
    );

    // pack the three arrays into status words
    assign issue.sr1_out  = '{busy: sr1_busy, rob_entry: sr1_tag, data: sr1_val};
    assign issue.sr2_out  = '{busy: sr2_busy, rob_entry: sr2_tag, data: sr2_val};
    assign issue.dest_out = '{busy: dest_busy, rob_entry: dest_tag, data: dest_val};

endmodule : regfile

`default_nettype wire

// ==== rtl/regfile_data.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile_data #(
    parameter int data_width = 16,
    parameter int tag_width  = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic [data_width-1:0] in,
    // source reads
    input  logic [tag_width-1:0]  sr1,
    input  logic [tag_width-1:0]  sr2,
    // write select, read back on dest_out
    input  logic [tag_width-1:0]  dest,
    // spare read port
    input  logic [tag_width-1:0]  dest_b,
    output logic [data_width-1:0] reg_a,
    output logic [data_width-1:0] reg_b,
    output logic [data_width-1:0] dest_out,
    output logic [data_width-1:0] dest_b_out
);
    import lc3b_isa_pkg::*;

    logic [data_width-1:0] mem [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // all entries start at zero
            for (int i = 0; i < num_regs; i++) begin
                mem[i] <= '0;
            end
        end else if (load) begin
            mem[dest] <= in;
        end
    end

    // four combinational read ports
    assign reg_a      = mem[sr1];
    assign reg_b      = mem[sr2];
    assign dest_out   = mem[dest];
    assign dest_b_out = mem[dest_b];

endmodule : regfile_data

`default_nettype wire

// ==== rtl/two_write_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module two_write_regfile #(
    parameter int data_width = 1,
    parameter int tag_width  = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    // port A has priority over port B
    input  logic                  load_a,
    input  logic                  load_b,
    input  logic [data_width-1:0] in_a,
    input  logic [data_width-1:0] in_b,
    // read selects
    input  logic [tag_width-1:0]  sr1,
    input  logic [tag_width-1:0]  sr2,
    // write selects, dest_a is also read back
    input  logic [tag_width-1:0]  dest_a,
    input  logic [tag_width-1:0]  dest_b,
    output logic [data_width-1:0] reg_a,
    output logic [data_width-1:0] reg_b,
    output logic [data_width-1:0] dest_out
);
    import lc3b_isa_pkg::*;

    // one entry per architectural register
    logic [data_width-1:0] mem [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            // flush wipes the whole array, both write ports ignored
            for (int i = 0; i < num_regs; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (load_b) begin
                mem[dest_b] <= in_b;
            end
            // later assignment wins on an address collision
            if (load_a) begin
                mem[dest_a] <= in_a;
            end
        end
    end

    // reads see the state before the edge
    assign reg_a    = mem[sr1];
    assign reg_b    = mem[sr2];
    assign dest_out = mem[dest_a];

endmodule : two_write_regfile

`default_nettype wire

// ==== rtl/rf_ports_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// issue control to register status file
interface rf_issue_if;
    import lc3b_isa_pkg::*;
    import rename_pkg::*;

    // load strobes for the destination entry
    logic         ld_busy;
    logic         ld_rob_entry;
    // source and destination selects
    lc3b_reg      sr1;
    lc3b_reg      sr2;
    lc3b_reg      dest;
    // tag of the ROB entry being allocated
    lc3b_rob_addr rob_entry;
    // combinational status reads
    regfile_t     sr1_out;
    regfile_t     sr2_out;
    regfile_t     dest_out;

    modport ctrl (
        output ld_busy, ld_rob_entry, sr1, sr2, dest, rob_entry,
        input  sr1_out, sr2_out, dest_out
    );

    modport file (
        input  ld_busy, ld_rob_entry, sr1, sr2, dest, rob_entry,
        output sr1_out, sr2_out, dest_out
    );
endinterface : rf_issue_if

// ROB commit to register status file
interface rf_commit_if;
    import lc3b_isa_pkg::*;
    import rename_pkg::*;

    logic         ld_value;
    // busy clear strobe
    logic         ld_busy;
    lc3b_word     value;
    lc3b_reg      dest;
    // current owner tag of dest
    lc3b_rob_addr dest_tag;

    modport ctrl (
        output ld_value, ld_busy, value, dest,
        input  dest_tag
    );

    modport file (
        input  ld_value, ld_busy, value, dest,
        output dest_tag
    );
endinterface : rf_commit_if

`default_nettype wire

// ==== rtl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // one tag per ROB entry, eight entries
    localparam int rob_tag_width = 3;

    typedef logic [rob_tag_width-1:0] lc3b_rob_addr;

    // status of one architectural register
    // rob_entry names the youngest in-flight writer
    typedef struct packed {
        logic                     busy;
        lc3b_rob_addr             rob_entry;
        lc3b_isa_pkg::lc3b_word   data;
    } regfile_t;

    // operand handed to a reservation station
    // value is meaningful only while ready is set, else wait on tag
    typedef struct packed {
        logic                     ready;
        lc3b_rob_addr             tag;
        lc3b_isa_pkg::lc3b_word   value;
    } operand_t;

endpackage : rename_pkg

`default_nettype wire

// ==== rtl/lc3b_isa_pkg.sv ====
`default_nettype none

package lc3b_isa_pkg;

    // architectural register index, R0 through R7
    typedef logic [2:0] lc3b_reg;

    // one machine word
    typedef logic [15:0] lc3b_word;

    // size of the architectural register file
    localparam int num_regs = 8;

endpackage : lc3b_isa_pkg

`default_nettype wire
